// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

   // base integer ISA word width
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0] reg_addr_t;

   // major opcode, instruction bits 6 to 2
   typedef logic [4:0] opcode_t;
   typedef logic [2:0] funct3_t;

   // major opcodes handled by the slice
   localparam opcode_t OPC_OP_IMM = 5'b00100;
   localparam opcode_t OPC_OP     = 5'b01100;
   localparam opcode_t OPC_LUI    = 5'b01101;

   // funct3 codes for the ALU group
   localparam funct3_t F3_ADD = 3'b000;
   localparam funct3_t F3_XOR = 3'b100;
   localparam funct3_t F3_OR  = 3'b110;
   localparam funct3_t F3_AND = 3'b111;

   // field positions in the instruction word
   localparam int OPC_LSB = 2;
   localparam int RD_LSB  = 7;
   localparam int F3_LSB  = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;

   // I-type immediate occupies bits 31..20
   localparam int IMM_I_LSB = 20;
   localparam int IMM_I_W   = 12;

   // U-type immediate occupies bits 31..12
   localparam int IMM_U_LSB = 12;
   localparam int IMM_U_W   = 20;

   // set on OP for sub, clear for add
   localparam int SUB_BIT = 30;

   // sign bit of every immediate format
   localparam int SIGN_BIT = 31;

endpackage

// ==== hw/serial_pkg.sv ====
package serial_pkg;

   // one instruction walks IDLE -> READ -> RUN -> WRITE
   typedef enum logic [1:0] {
      IDLE,
      READ,
      RUN,
      WRITE
   } dec_state_t;

   // counts the 32 bit-serial cycles of RUN
   typedef logic [4:0] bit_cnt_t;

   localparam bit_cnt_t CNT_FIRST = 5'd0;
   localparam bit_cnt_t CNT_LAST  = 5'd31;

   // which ALU output feeds the result shift register
   typedef enum logic [1:0] {
      RD_SEL_ADD,
      RD_SEL_BOOL,
      RD_SEL_IMM
   } rd_sel_t;

   // boolean op is funct3[1:0]
   typedef logic [1:0] bool_op_t;

   localparam bool_op_t BOOL_XOR = 2'b00;
   localparam bool_op_t BOOL_OR  = 2'b10;
   localparam bool_op_t BOOL_AND = 2'b11;

endpackage

// ==== hw/serial_decode.sv ====
module serial_decode (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_valid,
   input  rv_isa_pkg::word_t     i_instr,
   output logic                  o_ready,
   output rv_isa_pkg::reg_addr_t o_rs1_addr,
   output rv_isa_pkg::reg_addr_t o_rs2_addr,
   output rv_isa_pkg::reg_addr_t o_rd_addr,
   output logic                  o_rd_en,
   output logic                  o_rf_read,
   output logic                  o_rf_shift,
   output logic                  o_rf_write,
   output logic                  o_imm_bit,
   output logic                  o_op_b_rs2,
   output logic                  o_alu_sub,
   output logic                  o_alu_init,
   output serial_pkg::bool_op_t  o_bool_op,
   output serial_pkg::rd_sel_t   o_rd_sel
);

   import rv_isa_pkg::*;
   import serial_pkg::*;

   dec_state_t state;
   bit_cnt_t   cnt;

   // fields held for the whole instruction
   opcode_t    opcode;
   funct3_t    funct3;
   logic       sub_marker;
   word_t      imm;

   logic       accept;
   logic       is_op;
   logic       is_op_imm;
   logic       is_lui;
   logic       f3_ok;
   logic       supported;
   opcode_t    new_opcode;

   assign accept     = i_valid & o_ready;
   assign new_opcode = i_instr[OPC_LSB +: 5];

   always_ff @(posedge clk) begin
      if (accept) begin
         opcode     <= new_opcode;
         funct3     <= i_instr[F3_LSB +: 3];
         sub_marker <= i_instr[SUB_BIT];
         o_rd_addr  <= i_instr[RD_LSB +: 5];
         o_rs1_addr <= i_instr[RS1_LSB +: 5];
         o_rs2_addr <= i_instr[RS2_LSB +: 5];
      end
   end

   // immediate is built on acceptance, then rotated one bit per RUN cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         if (new_opcode == OPC_LUI) begin
            imm <= {i_instr[IMM_U_LSB +: IMM_U_W], 12'd0};
         end else begin
            imm <= {{(XLEN - IMM_I_W){i_instr[SIGN_BIT]}}, i_instr[IMM_I_LSB +: IMM_I_W]};
         end
      end else if (state == RUN) begin
         imm <= {imm[0], imm[XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= IDLE;
         cnt   <= CNT_FIRST;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= READ;
               end
            end
            READ: begin
               state <= RUN;
            end
            RUN: begin
               cnt <= cnt + 5'd1;
               // counter wraps back to zero here
               if (cnt == CNT_LAST) begin
                  state <= WRITE;
               end
            end
            WRITE: begin
               state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign o_ready    = (state == IDLE);
   assign o_rf_read  = (state == READ);
   assign o_rf_shift = (state == RUN);
   assign o_rf_write = (state == WRITE);
   assign o_alu_init = (state == RUN) & (cnt == CNT_FIRST);
   assign o_imm_bit  = imm[0];

   assign is_op     = (opcode == OPC_OP);
   assign is_op_imm = (opcode == OPC_OP_IMM);
   assign is_lui    = (opcode == OPC_LUI);
   assign f3_ok     = (funct3 == F3_ADD) | (funct3 == F3_XOR) |
                      (funct3 == F3_OR) | (funct3 == F3_AND);
   assign supported = is_lui | ((is_op | is_op_imm) & f3_ok);

   // x0 never gets written
   assign o_rd_en    = supported & (o_rd_addr != 5'd0);
   assign o_op_b_rs2 = is_op;
   assign o_alu_sub  = is_op & sub_marker & (funct3 == F3_ADD);
   assign o_bool_op  = funct3[1:0];

   always_comb begin
      if (is_lui) begin
         o_rd_sel = RD_SEL_IMM;
      end else if (funct3 == F3_ADD) begin
         o_rd_sel = RD_SEL_ADD;
      end else begin
         o_rd_sel = RD_SEL_BOOL;
      end
   end

endmodule

// ==== hw/serial_alu.sv ====
module serial_alu (
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_init,
   input  logic                 i_sub,
   input  logic                 i_op_b_rs2,
   input  logic                 i_rs1_bit,
   input  logic                 i_rs2_bit,
   input  logic                 i_imm_bit,
   input  serial_pkg::bool_op_t i_bool_op,
   input  serial_pkg::rd_sel_t  i_rd_sel,
   output logic                 o_rd_bit
);

   import serial_pkg::*;

   logic carry;
   logic op_b;
   logic carry_in;
   logic carry_out;
   logic sum_bit;
   logic bool_bit;

   // subtract is add of the inverted operand with carry-in of one
   assign op_b     = (i_op_b_rs2 ? i_rs2_bit : i_imm_bit) ^ i_sub;
   assign carry_in = i_init ? i_sub : carry;

   assign sum_bit   = i_rs1_bit ^ op_b ^ carry_in;
   assign carry_out = (i_rs1_bit & op_b) | (i_rs1_bit & carry_in) | (op_b & carry_in);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry <= 1'b0;
      end else begin
         carry <= carry_out;
      end
   end

   always_comb begin
      case (i_bool_op)
         BOOL_XOR: bool_bit = i_rs1_bit ^ op_b;
         BOOL_OR:  bool_bit = i_rs1_bit | op_b;
         BOOL_AND: bool_bit = i_rs1_bit & op_b;
         default:  bool_bit = 1'b0;
      endcase
   end

   always_comb begin
      case (i_rd_sel)
         RD_SEL_ADD:  o_rd_bit = sum_bit;
         RD_SEL_BOOL: o_rd_bit = bool_bit;
         RD_SEL_IMM:  o_rd_bit = i_imm_bit;
         default:     o_rd_bit = 1'b0;
      endcase
   end

endmodule

// ==== hw/serial_regfile.sv ====
module serial_regfile #(
   parameter int REG_COUNT = 32
) (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_read,
   input  logic                  i_shift,
   input  logic                  i_write,
   input  logic                  i_wen,
   input  rv_isa_pkg::reg_addr_t i_rs1_addr,
   input  rv_isa_pkg::reg_addr_t i_rs2_addr,
   input  rv_isa_pkg::reg_addr_t i_rd_addr,
   input  logic                  i_rd_bit,
   output logic                  o_rs1_bit,
   output logic                  o_rs2_bit,
   output rv_isa_pkg::word_t     o_rd_word
);

   import rv_isa_pkg::*;

   // with 16 registers the top address bit drops out
   localparam int AW = $clog2(REG_COUNT);

   word_t regs [REG_COUNT];

   word_t rs1_sr;
   word_t rs2_sr;
   word_t rd_stage;

   logic [AW-1:0] rs1_idx;
   logic [AW-1:0] rs2_idx;
   logic [AW-1:0] rd_idx;

   assign rs1_idx = i_rs1_addr[AW-1:0];
   assign rs2_idx = i_rs2_addr[AW-1:0];
   assign rd_idx  = i_rd_addr[AW-1:0];

   // word storage, entry 0 stays zero
   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_write && i_wen && (rd_idx != '0)) begin
         regs[rd_idx] <= rd_stage;
      end
   end

   // operands leave lsb first
   always_ff @(posedge clk) begin
      if (i_read) begin
         rs1_sr <= regs[rs1_idx];
         rs2_sr <= regs[rs2_idx];
      end else if (i_shift) begin
         rs1_sr <= {1'b0, rs1_sr[XLEN-1:1]};
         rs2_sr <= {1'b0, rs2_sr[XLEN-1:1]};
      end
   end

   // result enters at the top, so after 32 shifts bit 0 sits at bit 0
   always_ff @(posedge clk) begin
      if (i_shift) begin
         rd_stage <= {i_rd_bit, rd_stage[XLEN-1:1]};
      end
   end

   assign o_rs1_bit = rs1_sr[0];
   assign o_rs2_bit = rs2_sr[0];
   assign o_rd_word = rd_stage;

endmodule

// ==== hw/serial_core.sv ====
module serial_core #(
   parameter int REG_COUNT = 32
) (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic                  i_valid,
   input  rv_isa_pkg::word_t     i_instr,
   output logic                  o_ready,
   output logic                  o_retire,
   output logic                  o_retire_wen,
   output rv_isa_pkg::reg_addr_t o_retire_rd,
   output rv_isa_pkg::word_t     o_retire_data
);

   import rv_isa_pkg::*;
   import serial_pkg::*;

   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      rd_en;
   logic      rf_read;
   logic      rf_shift;
   logic      rf_write;
   logic      imm_bit;
   logic      op_b_rs2;
   logic      alu_sub;
   logic      alu_init;
   bool_op_t  bool_op;
   rd_sel_t   rd_sel;
   logic      rs1_bit;
   logic      rs2_bit;
   logic      rd_bit;
   word_t     rd_word;

   serial_decode serial_decode_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_valid    (i_valid),
      .i_instr    (i_instr),
      .o_ready    (o_ready),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_rd_en    (rd_en),
      .o_rf_read  (rf_read),
      .o_rf_shift (rf_shift),
      .o_rf_write (rf_write),
      .o_imm_bit  (imm_bit),
      .o_op_b_rs2 (op_b_rs2),
      .o_alu_sub  (alu_sub),
      .o_alu_init (alu_init),
      .o_bool_op  (bool_op),
      .o_rd_sel   (rd_sel)
   );

   serial_alu serial_alu_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_init     (alu_init),
      .i_sub      (alu_sub),
      .i_op_b_rs2 (op_b_rs2),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .i_imm_bit  (imm_bit),
      .i_bool_op  (bool_op),
      .i_rd_sel   (rd_sel),
      .o_rd_bit   (rd_bit)
   );

   serial_regfile #(
      .REG_COUNT (REG_COUNT)
   ) serial_regfile_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_read     (rf_read),
      .i_shift    (rf_shift),
      .i_write    (rf_write),
      .i_wen      (rd_en),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit),
      .o_rd_word  (rd_word)
   );

   // retire trace follows the write-back cycle
   assign o_retire      = rf_write;
   assign o_retire_wen  = rd_en;
   assign o_retire_rd   = rd_addr;
   assign o_retire_data = rd_word;

endmodule

// ==== tb/serial_core_tb.sv ====
module serial_core_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import rv_isa_pkg::*;

   localparam int  REG_COUNT      = 32;
   localparam int  TIMEOUT_CYCLES = 100;
   localparam time PERIOD         = 4;
   localparam time RETIRE_TIMEOUT = PERIOD * 40;

   logic      clk;
   logic      i_rst;
   logic      i_valid;
   word_t     i_instr;
   logic      o_ready;
   logic      o_retire;
   logic      o_retire_wen;
   reg_addr_t o_retire_rd;
   word_t     o_retire_data;

   integer seed = 32'hd43c_1adc;

   // architectural view of the register file
   word_t shadow [32];

   // expected retires, oldest first
   logic      q_wen  [$];
   reg_addr_t q_rd   [$];
   word_t     q_data [$];
   time       q_time [$];

   serial_core #(
      .REG_COUNT (REG_COUNT)
   ) serial_core_i (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_valid       (i_valid),
      .i_instr       (i_instr),
      .o_ready       (o_ready),
      .o_retire      (o_retire),
      .o_retire_wen  (o_retire_wen),
      .o_retire_rd   (o_retire_rd),
      .o_retire_data (o_retire_data)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_eq(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         abort_run("compare failed");
      end
   endtask

   function automatic word_t rr_instr(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t ri_instr(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic word_t lui_instr(input logic [19:0] imm, input reg_addr_t rd);
      return {imm, rd, 7'b0110111};
   endfunction

   // with 16 registers the top address bit aliases
   function automatic reg_addr_t shadow_idx(input reg_addr_t a);
      return a & reg_addr_t'(REG_COUNT - 1);
   endfunction

   // ISA result of one instruction against the shadow registers
   function automatic word_t ref_result(input word_t instr, output logic wen);
      word_t a;
      word_t b;
      word_t opnd;
      word_t res;
      logic  ok;
      a    = shadow[shadow_idx(instr[19:15])];
      b    = shadow[shadow_idx(instr[24:20])];
      opnd = {{20{instr[31]}}, instr[31:20]};
      ok   = 1'b1;
      res  = '0;
      case (instr[6:0])
         7'b0110111: res = {instr[31:12], 12'h000};
         7'b0010011, 7'b0110011: begin
            if (instr[6:0] == 7'b0110011) begin
               // sub is add of the negated rs2
               opnd = (instr[30] && instr[14:12] == 3'b000) ? -b : b;
            end
            case (instr[14:12])
               3'b000:  res = a + opnd;
               3'b100:  res = a ^ opnd;
               3'b110:  res = a | opnd;
               3'b111:  res = a & opnd;
               default: ok = 1'b0;
            endcase
         end
         default: ok = 1'b0;
      endcase
      wen = ok && (instr[11:7] != 5'd0);
      return res;
   endfunction

   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk);
      while (!o_ready) begin
         n++;
         if (n > TIMEOUT_CYCLES) begin
            abort_run("timeout waiting for o_ready");
         end
         @(negedge clk);
      end
   endtask

   task automatic issue(input word_t instr);
      logic  wen;
      word_t data;
      wait_ready();
      @(posedge clk);
      i_valid <= 1'b1;
      i_instr <= instr;
      @(posedge clk);
      // accepting edge
      i_valid <= 1'b0;
      i_instr <= $random(seed);
      data = ref_result(instr, wen);
      q_wen.push_back(wen);
      q_rd.push_back(instr[11:7]);
      q_data.push_back(data);
      q_time.push_back($time);
      if (wen && shadow_idx(instr[11:7]) != 5'd0) begin
         shadow[shadow_idx(instr[11:7])] = data;
      end
   endtask

   task automatic drain_retires();
      int n;
      n = 0;
      while (q_wen.size() != 0) begin
         n++;
         if (n > TIMEOUT_CYCLES) begin
            abort_run("timeout waiting for the last retire");
         end
         @(negedge clk);
      end
   endtask

   // every retire is matched against the oldest accepted instruction
   initial begin : retire_check
      time lat;
      forever begin
         @(negedge clk);
         if (!i_rst && o_retire) begin
            if (q_wen.size() == 0) begin
               abort_run("o_retire without an accepted instruction");
            end else begin
               lat = ($time - q_time[0] + PERIOD / 2) / PERIOD;
               check_eq("o_retire_wen", word_t'(o_retire_wen), word_t'(q_wen[0]));
               check_eq("o_retire_rd", word_t'(o_retire_rd), word_t'(q_rd[0]));
               if (q_wen[0]) begin
                  check_eq("o_retire_data", o_retire_data, q_data[0]);
               end
               check_eq("retire latency", word_t'(lat), 34);
               void'(q_wen.pop_front());
               void'(q_rd.pop_front());
               void'(q_data.pop_front());
               void'(q_time.pop_front());
            end
         end else if (q_time.size() != 0 && $time - q_time[0] > RETIRE_TIMEOUT) begin
            abort_run("timeout waiting for o_retire");
         end
      end
   end

   initial begin : stimulus
      word_t       instr;
      int          sel;
      reg_addr_t   rd;
      reg_addr_t   rs1;
      reg_addr_t   rs2;
      logic [2:0]  f3;
      i_rst   = 1'b1;
      i_valid = 1'b0;
      i_instr = '0;
      for (int i = 0; i < 32; i++) begin
         shadow[i] = '0;
      end
      repeat (16) @(posedge clk);
      i_rst <= 1'b0;

      // idle core after reset
      repeat (8) begin
         @(negedge clk);
         check_eq("o_ready", word_t'(o_ready), 1);
         check_eq("o_retire", word_t'(o_retire), 0);
      end

      // seed registers from x0, including negative immediates
      issue(lui_instr(20'h12345, 5'd1));
      issue(ri_instr(12'hfff, 5'd0, 3'b000, 5'd2));
      issue(ri_instr(12'h800, 5'd0, 3'b000, 5'd3));
      issue(ri_instr(12'h7ff, 5'd0, 3'b000, 5'd4));
      issue(lui_instr(20'h80000, 5'd5));
      for (int r = 6; r < 32; r++) begin
         issue(lui_instr(20'($random(seed)), reg_addr_t'(r)));
         issue(ri_instr(12'($random(seed)), reg_addr_t'(r), 3'b000, reg_addr_t'(r)));
      end

      // wraparound cases
      issue(rr_instr(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
      issue(rr_instr(7'h20, 5'd1, 5'd0, 3'b000, 5'd7));
      issue(rr_instr(7'h00, 5'd2, 5'd2, 3'b000, 5'd8));

      repeat (60) begin
         sel = $unsigned($random(seed)) % 5;
         rd  = reg_addr_t'($random(seed));
         rs1 = reg_addr_t'($random(seed));
         rs2 = reg_addr_t'($random(seed));
         case (sel)
            0:       instr = rr_instr(7'h00, rs2, rs1, 3'b000, rd);
            1:       instr = rr_instr(7'h20, rs2, rs1, 3'b000, rd);
            2:       instr = rr_instr(7'h00, rs2, rs1, 3'b100, rd);
            3:       instr = rr_instr(7'h00, rs2, rs1, 3'b110, rd);
            default: instr = rr_instr(7'h00, rs2, rs1, 3'b111, rd);
         endcase
         issue(instr);
      end

      repeat (40) begin
         sel = $unsigned($random(seed)) % 4;
         rd  = reg_addr_t'($random(seed));
         rs1 = reg_addr_t'($random(seed));
         case (sel)
            0:       f3 = 3'b000;
            1:       f3 = 3'b100;
            2:       f3 = 3'b110;
            default: f3 = 3'b111;
         endcase
         issue(ri_instr(12'($random(seed)), rs1, f3, rd));
      end

      // writes to x0, then reads of x0
      issue(ri_instr(12'h005, 5'd1, 3'b000, 5'd0));
      issue(rr_instr(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
      issue(rr_instr(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
      issue(ri_instr(12'h000, 5'd0, 3'b110, 5'd12));

      // load, sll and slti are not decoded, so x10 keeps its value
      issue({12'h004, 5'd1, 3'b010, 5'd10, 7'b0000011});
      issue(rr_instr(7'h00, 5'd2, 5'd1, 3'b001, 5'd10));
      issue(ri_instr(12'h001, 5'd1, 3'b010, 5'd10));
      issue(rr_instr(7'h00, 5'd0, 5'd10, 3'b000, 5'd11));

      // strobe while busy must be dropped
      issue(ri_instr(12'h123, 5'd3, 3'b100, 5'd13));
      repeat (5) @(posedge clk);
      i_valid <= 1'b1;
      i_instr <= ri_instr(12'h001, 5'd0, 3'b000, 5'd14);
      @(negedge clk);
      check_eq("o_ready", word_t'(o_ready), 0);
      @(posedge clk);
      i_valid <= 1'b0;
      issue(rr_instr(7'h00, 5'd14, 5'd13, 3'b000, 5'd15));

      drain_retires();
      repeat (40) @(negedge clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== project.f ====
hw/rv_isa_pkg.sv
hw/serial_pkg.sv
hw/serial_decode.sv
hw/serial_alu.sv
hw/serial_regfile.sv
hw/serial_core.sv
tb/serial_core_tb.sv

// ==== Makefile ====
TOP := serial_core_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f project.f \
		--top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f project.f \
		--top-module serial_core

clean:
	rm -rf obj_dir $(LOG)
